//--- vlog.f
hw/isa_pkg.sv
hw/rs_pkg.sv
hw/rs_entry.sv
hw/rs_bank.sv
hw/issue_select.sv
hw/alu_cdb_stage.sv
hw/rs_issue_top.sv
sim/rs_checker.sv
sim/rs_issue_assert.sv
sim/tb_rs_issue.sv

//--- Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module tb_rs_issue -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vtb_rs_issue | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

//--- sim/rs_stim.txt
# I dest op br qj qk vj vk rob | L tag value step | E tag result | B busy | S level
# W cycles | F flush | T test number | D end of test; values and busy in hex
T 1
E 1 0000000a
E 2 fffffffe
E 3 00000100
E 4 00000001
E 5 00000001
I 0 0 0 0 0 00000003 00000007 1
I 1 1 0 0 0 00000005 00000007 2
I 2 5 0 0 0 00000001 00000008 3
I 3 7 0 0 0 ffffffff 00000001 4
I 0 0 1 0 0 00000005 00000005 5
D
T 2
E 6 00000064
I 0 0 0 9 0 00000000 00000004 6
W 2
L 9 00000060 0
D
T 3
E 7 00000033
I 1 4 0 0 10 0000000f 00000000 7
L 10 000000ff 1
W 2
B 2
L 10 0000003c 0
D
T 4
E 8 00000006
E 11 00000007
E 13 00000105
I 2 0 0 12 0 00000000 00000005 13
I 1 3 0 8 0 00000000 00000001 11
I 0 0 0 0 0 00000002 00000004 8
L 12 00000100 0
D
T 5
S 1
I 0 0 0 0 0 00000001 00000001 14
W 2
B 0
S 0
W 4
D
T 6
I 0 0 0 15 0 00000000 00000001 1
I 1 0 0 15 0 00000000 00000002 2
B 3
F
B 0
L 15 00000010 0
W 4
D

//--- sim/tb_rs_issue.sv
//********************
// Issue slice testbench
// Replays the stimulus file against the DUT
//********************
`timescale 1ns/1ps

module tb_rs_issue;
    import isa_pkg::*;
    import rs_pkg::*;

    logic            clk;
    logic            reset;
    logic            mispredicted;
    logic            stall;
    rs_idx_t         issue_dest;
    rs_data_t        issue_data;
    cdb_packet_t     load_cdb;
    logic [NUM_RS-1:0] busy_bus;
    cdb_packet_t     cdb;
    int cycle_count = 0;
    int limit = 0;
    int tb_errors = 0;
    int tests_run = 0;

    rs_issue_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .mispredicted (mispredicted),
        .stall        (stall),
        .issue_dest   (issue_dest),
        .issue_data   (issue_data),
        .load_cdb     (load_cdb),
        .busy_bus     (busy_bus),
        .cdb          (cdb)
    );

    rs_checker chk_i (
        .clk      (clk),
        .reset    (reset),
        .cdb      (cdb),
        .load_cdb (load_cdb),
        .busy_bus (busy_bus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (limit > 0 && cycle_count > limit) begin
            $display("timeout: run passed its limit of %0d cycles", limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic issue_op(input int dest, input int op, input int br, input int qj,
                            input int qk, input logic [XLEN-1:0] vj,
                            input logic [XLEN-1:0] vk, input int rob);
        rs_data_t d;
        d = '0;
        d.q_j = rob_tag_t'(qj);
        d.q_k = rob_tag_t'(qk);
        d.v_j = vj;
        d.v_k = vk;
        d.rob_entry = rob_tag_t'(rob);
        d.alu_op = alu_op_e'(op);
        d.branch_type = branch_type_e'(br);
        d.busy = 1'b1;
        @(posedge clk);
        issue_dest <= rs_idx_t'(dest);
        issue_data <= d;
        @(posedge clk);
        issue_dest <= 3'd7;
    endtask

    task automatic send_load(input int tag, input logic [XLEN-1:0] value, input int step);
        cdb_packet_t p;
        p.valid = 1'b1;
        p.dest_rob_entry = rob_tag_t'(tag);
        p.result = value;
        p.load_step1 = (step != 0);
        @(posedge clk);
        load_cdb <= p;
        @(posedge clk);
        load_cdb <= '0;
    endtask

    task automatic flush_all();
        @(posedge clk);
        mispredicted <= 1'b1;
        chk_i.note_flush();
        @(posedge clk);
        mispredicted <= 1'b0;
    endtask

    // Waits until outstanding results arrive or the per-test bound runs out
    task automatic finish_test(input int id);
        int waited;
        waited = 0;
        while (chk_i.pending_count != 0 && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        chk_i.end_test(id);
        tests_run++;
    endtask

    task automatic reject_record(input string text);
        $display("stimulus record could not be read: %s", text);
        tb_errors++;
    endtask

    initial begin
        int fd;
        int n;
        int n_rec;
        int a[8];
        logic [XLEN-1:0] va;
        logic [XLEN-1:0] vb;
        string line;
        string rest;
        byte cmd;
        int errors;
        reset = 1'b1;
        mispredicted = 1'b0;
        stall = 1'b0;
        issue_dest = 3'd7;
        issue_data = '0;
        load_cdb = '0;
        n_rec = 0;
        fd = $fopen("sim/rs_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file sim/rs_stim.txt");
            tb_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                    n_rec++;
                end
            end
            $fclose(fd);
            limit = n_rec * 50 + 20;
            repeat (5) @(posedge clk);
            reset <= 1'b0;
            fd = $fopen("sim/rs_stim.txt", "r");
            while ($fgets(line, fd) != 0) begin
                cmd = (line.len() > 0) ? line.getc(0) : "#";
                rest = line.substr(1, line.len() - 1);
                case (cmd)
                    "I": begin
                        n = $sscanf(rest, "%d %d %d %d %d %h %h %d",
                                    a[0], a[1], a[2], a[3], a[4], va, vb, a[5]);
                        if (n == 8)
                            issue_op(a[0], a[1], a[2], a[3], a[4], va, vb, a[5]);
                        else
                            reject_record(line);
                    end
                    "L": begin
                        n = $sscanf(rest, "%d %h %d", a[0], va, a[1]);
                        if (n == 3)
                            send_load(a[0], va, a[1]);
                        else
                            reject_record(line);
                    end
                    "E": begin
                        n = $sscanf(rest, "%d %h", a[0], va);
                        if (n == 2)
                            chk_i.add_expect(a[0], va);
                        else
                            reject_record(line);
                    end
                    "S": begin
                        n = $sscanf(rest, "%d", a[0]);
                        if (n == 1) begin
                            @(posedge clk);
                            stall <= (a[0] != 0);
                        end else begin
                            reject_record(line);
                        end
                    end
                    "W": begin
                        n = $sscanf(rest, "%d", a[0]);
                        if (n == 1)
                            repeat (a[0]) @(posedge clk);
                        else
                            reject_record(line);
                    end
                    "B": begin
                        n = $sscanf(rest, "%h", a[0]);
                        if (n == 1) begin
                            @(negedge clk);
                            chk_i.check_busy(a[0][NUM_RS-1:0]);
                        end else begin
                            reject_record(line);
                        end
                    end
                    "T": begin
                        n = $sscanf(rest, "%d", a[7]);
                        if (n != 1)
                            reject_record(line);
                    end
                    "F": flush_all();
                    "D": finish_test(a[7]);
                    default: begin
                        // Comment and blank lines carry no record
                        if (cmd != "#" && cmd != "\n")
                            reject_record(line);
                    end
                endcase
            end
            $fclose(fd);
        end
        errors = tb_errors + chk_i.error_count + dut_i.rs_issue_assert_i.fail_count;
        $display("tests %0d, results checked %0d, errors %0d", tests_run,
                 chk_i.check_count, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim/rs_issue_assert.sv
//********************
// Issue slice assertions
// Selector grant and bank flush properties
//********************
`timescale 1ns/1ps

module rs_issue_assert (
    input logic                        clk,
    input logic                        reset,
    input logic                        mispredicted,
    input logic [rs_pkg::NUM_RS-1:0]   busy_bus,
    input logic [rs_pkg::NUM_RS-1:0]   consumed_bus
);
    int fail_count = 0;

    a_one_grant: assert property (@(posedge clk) disable iff (reset) $onehot0(consumed_bus))
        else begin fail_count++; $error("more than one consumed bit set"); end

    a_grant_busy: assert property (@(posedge clk) disable iff (reset)
        (consumed_bus & ~busy_bus) == '0)
        else begin fail_count++; $error("consumed bit without busy station"); end

    // Every station is empty one cycle after a flush
    a_flush_empty: assert property (@(posedge clk) disable iff (reset)
        mispredicted |=> busy_bus == '0)
        else begin fail_count++; $error("stations still busy after flush"); end

endmodule

bind rs_issue_top rs_issue_assert rs_issue_assert_i (
    .clk          (clk),
    .reset        (reset),
    .mispredicted (mispredicted),
    .busy_bus     (busy_bus),
    .consumed_bus (consumed_bus)
);

//--- sim/rs_checker.sv
//********************
// CDB checker
// Compares ALU broadcasts and busy bits with expected values
//********************
`timescale 1ns/1ps

module rs_checker (
    input logic                      clk,
    input logic                      reset,
    input rs_pkg::cdb_packet_t       cdb,
    input rs_pkg::cdb_packet_t       load_cdb,
    input logic [rs_pkg::NUM_RS-1:0] busy_bus
);
    import isa_pkg::*;
    import rs_pkg::*;

    localparam int NUM_TAGS = 2 ** ROB_TAG_W;

    logic [XLEN-1:0] exp_value [NUM_TAGS];
    logic            exp_valid [NUM_TAGS];
    logic            flushed [NUM_TAGS];
    int pending_count = 0;
    int error_count = 0;
    int check_count = 0;
    int test_errors = 0;
    int test_checks = 0;

    initial begin
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_valid[i] = 1'b0;
            flushed[i] = 1'b0;
            exp_value[i] = '0;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        error_count++;
        test_errors++;
    endtask

    task automatic add_expect(input int tag, input logic [XLEN-1:0] value);
        exp_value[tag] = value;
        exp_valid[tag] = 1'b1;
        flushed[tag] = 1'b0;
        pending_count++;
    endtask

    // Results still outstanding at a flush must never show up
    task automatic note_flush();
        for (int i = 0; i < NUM_TAGS; i++) begin
            if (exp_valid[i]) begin
                flushed[i] = 1'b1;
                exp_valid[i] = 1'b0;
            end
        end
        pending_count = 0;
    endtask

    task automatic check_busy(input logic [NUM_RS-1:0] mask);
        if (busy_bus !== mask) begin
            report_error($sformatf("mismatch at %0t: busy_bus expected %h got %h",
                                   $time, mask, busy_bus));
        end
    endtask

    task automatic end_test(input int id);
        if (pending_count != 0) begin
            report_error($sformatf("test %0d: %0d expected results never appeared",
                                   id, pending_count));
        end
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_valid[i] = 1'b0;
        end
        pending_count = 0;
        $display("test %0d: %0d results checked, %0d errors", id, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    always @(negedge clk) begin
        if (!reset && load_cdb.valid) begin
            // A valid load packet goes straight through to the bus
            if (cdb !== load_cdb) begin
                report_error($sformatf("mismatch at %0t: cdb expected %h got %h",
                                       $time, load_cdb, cdb));
            end
        end else if (!reset && cdb.valid) begin
            // The bus carries an ALU result whenever no load packet owns it
            if (exp_valid[cdb.dest_rob_entry]) begin
                check_count++;
                test_checks++;
                pending_count--;
                exp_valid[cdb.dest_rob_entry] = 1'b0;
                if (cdb.result !== exp_value[cdb.dest_rob_entry]) begin
                    report_error($sformatf("mismatch at %0t: cdb.result tag %0d expected %h got %h",
                        $time, cdb.dest_rob_entry, exp_value[cdb.dest_rob_entry], cdb.result));
                end
                // Issued ops are never loads
                if (cdb.load_step1 !== 1'b0) begin
                    report_error($sformatf("mismatch at %0t: cdb.load_step1 tag %0d expected 0 got %b",
                        $time, cdb.dest_rob_entry, cdb.load_step1));
                end
            end else if (flushed[cdb.dest_rob_entry]) begin
                report_error($sformatf("broadcast at %0t for tag %0d that was flushed",
                                       $time, cdb.dest_rob_entry));
            end else begin
                report_error($sformatf("broadcast at %0t for tag %0d that nobody expects",
                                       $time, cdb.dest_rob_entry));
            end
        end
    end

endmodule

//--- hw/rs_issue_top.sv
//********************
// Issue to execute slice
// Station bank, selector and ALU/CDB stage
//********************
`timescale 1ns/1ps

module rs_issue_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             mispredicted,
    input  logic                             stall,
    input  rs_pkg::rs_idx_t                  issue_dest,
    input  rs_pkg::rs_data_t                 issue_data,
    input  rs_pkg::cdb_packet_t              load_cdb,
    output logic [rs_pkg::NUM_RS-1:0]        busy_bus,
    output rs_pkg::cdb_packet_t              cdb
);
    import rs_pkg::*;

    rs_out_t [NUM_RS-1:0] rs_out;
    rs_out_t              dispatch;
    logic                 dispatch_go;
    logic [NUM_RS-1:0]    consumed_bus;
    logic                 alu_ready;

    rs_bank rs_bank_i (
        .clk          (clk),
        .reset        (reset),
        .mispredicted (mispredicted),
        .stall        (stall),
        .rs_dest      (issue_dest),
        .d            (issue_data),
        .cdb_in       (cdb),
        .consumed_bus (consumed_bus),
        .busy_bus     (busy_bus),
        .rs_out       (rs_out)
    );

    issue_select issue_select_i (
        .busy_bus     (busy_bus),
        .rs_out       (rs_out),
        .alu_ready    (alu_ready),
        .dispatch     (dispatch),
        .dispatch_go  (dispatch_go),
        .consumed_bus (consumed_bus)
    );

    alu_cdb_stage alu_cdb_stage_i (
        .clk          (clk),
        .reset        (reset),
        .mispredicted (mispredicted),
        .dispatch     (dispatch),
        .dispatch_go  (dispatch_go),
        .load_cdb     (load_cdb),
        .alu_ready    (alu_ready),
        .cdb          (cdb)
    );

endmodule

//--- hw/alu_cdb_stage.sv
//********************
// ALU and CDB stage
// Registered ALU result, held while a load packet owns the bus
//********************
`timescale 1ns/1ps

module alu_cdb_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                mispredicted,
    input  rs_pkg::rs_out_t     dispatch,
    input  logic                dispatch_go,
    input  rs_pkg::cdb_packet_t load_cdb,
    output logic                alu_ready,
    output rs_pkg::cdb_packet_t cdb
);
    import isa_pkg::*;
    import rs_pkg::*;

    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] result;
    cdb_packet_t     held;

    always_comb begin
        alu_result = '0;
        case (dispatch.alu_op)
            alu_add: alu_result = dispatch.op_a + dispatch.op_b;
            alu_sub: alu_result = dispatch.op_a - dispatch.op_b;
            alu_and: alu_result = dispatch.op_a & dispatch.op_b;
            alu_or:  alu_result = dispatch.op_a | dispatch.op_b;
            alu_xor: alu_result = dispatch.op_a ^ dispatch.op_b;
            alu_sll: alu_result = dispatch.op_a << dispatch.op_b[SHAMT_W-1:0];
            alu_srl: alu_result = dispatch.op_a >> dispatch.op_b[SHAMT_W-1:0];
            alu_slt: alu_result = XLEN'($signed(dispatch.op_a) < $signed(dispatch.op_b));
        endcase
    end

    // Branches report the condition as 1 or 0
    always_comb begin
        case (dispatch.branch_type)
            br_eq:   result = XLEN'(dispatch.op_a == dispatch.op_b);
            br_ne:   result = XLEN'(dispatch.op_a != dispatch.op_b);
            br_lt:   result = XLEN'($signed(dispatch.op_a) < $signed(dispatch.op_b));
            default: result = alu_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || mispredicted) begin
            held.valid <= 1'b0;
        end else if (dispatch_go) begin
            held.valid <= 1'b1;
            held.dest_rob_entry <= dispatch.rob_entry;
            held.result <= result;
            // Load ops send their address step
            held.load_step1 <= dispatch.load;
        end else if (!load_cdb.valid) begin
            // Held result got the bus this cycle
            held.valid <= 1'b0;
        end
    end

    // Stall dispatch only while a result waits behind a load
    assign alu_ready = !held.valid || !load_cdb.valid;

    always_comb begin
        if (load_cdb.valid) begin
            cdb = load_cdb;
        end else begin
            cdb = held;
            // Result is dropped in the flush cycle
            cdb.valid = held.valid && !mispredicted;
        end
    end

endmodule

//--- hw/issue_select.sv
//********************
// Issue selector
// Grants the lowest ready station to the ALU
//********************
`timescale 1ns/1ps

module issue_select (
    input  logic [rs_pkg::NUM_RS-1:0]                busy_bus,
    input  rs_pkg::rs_out_t [rs_pkg::NUM_RS-1:0]     rs_out,
    input  logic                                     alu_ready,
    output rs_pkg::rs_out_t                          dispatch,
    output logic                                     dispatch_go,
    output logic [rs_pkg::NUM_RS-1:0]                consumed_bus
);
    import rs_pkg::*;

    logic [NUM_RS-1:0] ready;
    logic [NUM_RS-1:0] pick;

    for (genvar i = 0; i < NUM_RS; i++) begin : g_ready
        assign ready[i] = busy_bus[i] && rs_out[i].valid_operands;
    end

    always_comb begin
        dispatch = '0;
        pick = '0;
        // Walk downwards so the lowest ready station wins
        for (int i = NUM_RS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                dispatch = rs_out[i];
                pick = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign dispatch_go = alu_ready && (ready != '0);
    // One-hot pulse, only when the ALU takes the op
    assign consumed_bus = alu_ready ? pick : '0;

endmodule

//--- hw/rs_bank.sv
//********************
// Reservation station bank
// Four stations with write decode, stall gating and clearing
//********************
`timescale 1ns/1ps

module rs_bank (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     mispredicted,
    input  logic                                     stall,
    input  rs_pkg::rs_idx_t                          rs_dest,
    input  rs_pkg::rs_data_t                         d,
    input  rs_pkg::cdb_packet_t                      cdb_in,
    input  logic [rs_pkg::NUM_RS-1:0]                consumed_bus,
    output logic [rs_pkg::NUM_RS-1:0]                busy_bus,
    output rs_pkg::rs_out_t [rs_pkg::NUM_RS-1:0]     rs_out
);
    import rs_pkg::*;

    logic [NUM_RS-1:0] wr_en;
    logic [NUM_RS-1:0] clear;

    for (genvar i = 0; i < NUM_RS; i++) begin : g_rs
        // Destinations past the last station write nothing
        assign wr_en[i] = !stall && (rs_dest == rs_idx_t'(i));
        // Flush empties all, dispatch empties only the granted one
        assign clear[i] = mispredicted || consumed_bus[i];

        rs_entry rs_entry_i (
            .clk    (clk),
            .reset  (reset),
            .clear  (clear[i]),
            .wr_en  (wr_en[i]),
            .d      (d),
            .cdb_in (cdb_in),
            .busy   (busy_bus[i]),
            .out    (rs_out[i])
        );
    end

endmodule

//--- hw/rs_entry.sv
//********************
// Reservation station entry
// One station register that captures missing operands from the CDB
//********************
`timescale 1ns/1ps

module rs_entry (
    input  logic                clk,
    input  logic                reset,
    input  logic                clear,
    input  logic                wr_en,
    input  rs_pkg::rs_data_t    d,
    input  rs_pkg::cdb_packet_t cdb_in,
    output logic                busy,
    output rs_pkg::rs_out_t     out
);
    import rs_pkg::*;

    rs_data_t q_reg;
    logic     snoop_ok;
    logic     hit_j;
    logic     hit_k;

    // Only real results count, address steps are skipped
    assign snoop_ok = cdb_in.valid && !cdb_in.load_step1;
    assign hit_j = snoop_ok && (q_reg.q_j != '0) && (cdb_in.dest_rob_entry == q_reg.q_j);
    assign hit_k = snoop_ok && (q_reg.q_k != '0) && (cdb_in.dest_rob_entry == q_reg.q_k);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            q_reg <= '0;
        end else if (wr_en) begin
            // New entry does not snoop in its write cycle
            q_reg <= d;
        end else begin
            if (hit_j) begin
                q_reg.q_j <= '0;
                q_reg.v_j <= cdb_in.result;
            end
            if (hit_k) begin
                q_reg.q_k <= '0;
                q_reg.v_k <= cdb_in.result;
            end
        end
    end

    assign busy = q_reg.busy;

    // Ready once both producers are known and the entry holds an op
    always_comb begin
        out.valid_operands = (q_reg.q_j == '0) && (q_reg.q_k == '0) && (q_reg.rob_entry != '0);
        out.alu_op = q_reg.alu_op;
        out.rob_entry = q_reg.rob_entry;
        out.branch_type = q_reg.branch_type;
        out.op_a = q_reg.v_j;
        out.op_b = q_reg.v_k;
        out.load = q_reg.load;
    end

endmodule

//--- hw/rs_pkg.sv
//********************
// Reservation station types
// ROB tag, station entry, station output and CDB packet
//********************
package rs_pkg;
    import isa_pkg::*;

    localparam int NUM_RS = 4;
    localparam int ROB_TAG_W = 4;

    // Tag 0 means no dependency, or an empty entry
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Issue destination, values 4 to 7 select no station
    typedef logic [2:0] rs_idx_t;

    typedef struct packed {
        rob_tag_t        q_j;
        rob_tag_t        q_k;
        logic [XLEN-1:0] v_j;
        logic [XLEN-1:0] v_k;
        rob_tag_t        rob_entry;
        alu_op_e         alu_op;
        branch_type_e    branch_type;
        logic            load;
        logic            busy;
    } rs_data_t;

    // What a station offers to the selector
    typedef struct packed {
        logic            valid_operands;
        alu_op_e         alu_op;
        rob_tag_t        rob_entry;
        branch_type_e    branch_type;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic            load;
    } rs_out_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        dest_rob_entry;
        logic [XLEN-1:0] result;
        // Address step of a load, stations do not snoop it
        logic            load_step1;
    } cdb_packet_t;

endpackage

//--- hw/isa_pkg.sv
//********************
// ISA definitions
// Data word width, ALU opcodes and branch kinds
//********************
package isa_pkg;

    localparam int XLEN = 32;
    // Shift amount width for sll and srl
    localparam int SHAMT_W = $clog2(XLEN);

    // ALU operations carried by every station entry
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7
    } alu_op_e;

    // Branch compare kinds, br_none for plain ALU ops
    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_eq   = 2'd1,
        br_ne   = 2'd2,
        br_lt   = 2'd3
    } branch_type_e;

endpackage
